//--- filelist.f
+incdir+common
common/isaPkg.sv
common/corePkg.sv
hw/phaseSequencer.sv
decoder/jumpGroupDecoder.sv
decoder/aluGroupDecoder.sv
hw/registerFile.sv
hw/alu.sv
hw/programCounter.sv
hw/cpuCore.sv
testbench/cpuCore_assert.sv
testbench/cpuCore_tb.sv

//--- Bender.yml
package:
  name: cpu_core_slice

sources:
  - include_dirs:
      - common
    files:
      - common/isaPkg.sv
      - common/corePkg.sv
      - hw/phaseSequencer.sv
      - decoder/jumpGroupDecoder.sv
      - decoder/aluGroupDecoder.sv
      - hw/registerFile.sv
      - hw/alu.sv
      - hw/programCounter.sv
      - hw/cpuCore.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - testbench/cpuCore_assert.sv
      - testbench/cpuCore_tb.sv

//--- testbench/cpuCore_tb.sv
`include "cpu_config.svh"

`default_nettype none

module cpuCore_tb;
	timeunit 1ns;
	timeprecision 1ps;

	import isaPkg::*;
	import corePkg::*;

	localparam int retireCount = 400;
	localparam int resetCycles = 10;
	// four cycles per instruction, reset and some slack.
	localparam int cycleLimit = 4 * retireCount + resetCycles + 50;

	logic    CLK;
	logic    reset;
	instr_t  instr;
	word_t   instrAddr;
	retire_t retire;

	// program and reference state.
	instr_t  rom [256];
	word_t   mRegs [`REG_COUNT];
	word_t   mPc;
	flags_t  mFlags;
	int      valueErrors;
	int      otherErrors;
	int      cycles;

	cpuCore dut_i (
		.CLK(CLK), .reset(reset), .instr(instr), .instrAddr(instrAddr), .retire(retire)
	);

	always #10 CLK = ~CLK;

	// rom indexed by the low address byte.
	always @(negedge CLK) begin
		instr <= rom[instrAddr[7:0]];
	end

	// run limit.
	always @(posedge CLK) begin
		cycles++;
		if (cycles >= cycleLimit) begin
			$display("timeout after %0d cycles with the run still going", cycles);
			$display("Something failed");
			$finish;
		end
	end

	task automatic checkWord(input string name, input word_t got, input word_t expected);
		if (got !== expected) begin
			valueErrors++;
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, expected);
		end
	endtask

	task automatic checkFlags(input string name, input flags_t got, input flags_t expected);
		if (got !== expected) begin
			valueErrors++;
			$display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, expected);
		end
	endtask

	task automatic checkWrite(input logic expEn, input regAddr_t expAddr, input word_t expData);
		if (retire.writeEn !== expEn) begin
			valueErrors++;
			$display("CHECK FAILED at %0t: retire.writeEn got %b expected %b",
				$time, retire.writeEn, expEn);
		end else if (expEn) begin
			if (retire.writeAddr !== expAddr) begin
				valueErrors++;
				$display("CHECK FAILED at %0t: retire.writeAddr got %0d expected %0d",
					$time, retire.writeAddr, expAddr);
			end
			checkWord("retire.writeData", retire.writeData, expData);
		end
	endtask

	function automatic instr_t aluInstr(input logic [3:0] op, input logic [1:0] argf,
			input logic [3:0] a, input logic [3:0] b);
		return {GRP_ALU, op, argf, a, b};
	endfunction

	// cond is {apply, invert}.
	function automatic instr_t jumpInstr(input logic [1:0] cond, input logic [1:0] jpf,
			input logic [1:0] cc, input logic [7:0] imm);
		return {GRP_JUMP, cond, jpf, cc, imm};
	endfunction

	// mostly jumps and ALU ops.
	function automatic instr_t randomInstr();
		logic [13:0] bits;
		int          kind;
		bits = 14'($urandom);
		kind = $urandom % 16;
		if (kind == 0) return {GRP_SYSTEM, bits};
		if (kind == 1) return {GRP_LOADSTORE, bits};
		if (kind < 8) return {GRP_JUMP, bits};
		// codes 7 and 8 are undefined.
		return aluInstr(4'($urandom % 9), bits[9:8], bits[7:4], bits[3:0]);
	endfunction

	// executes rom[pc] on the model and compares the retire report.
	task automatic retireAndCheck();
		instr_t   ins;
		word_t    a;
		word_t    b;
		word_t    res;
		word_t    target;
		word_t    expNext;
		regAddr_t wa;
		logic     en;
		logic     cond;
		logic     setFlags;
		logic     [3:0] fv;
		int       sa;
		int       sb;
		flags_t   nf;
		ins = rom[mPc[7:0]];
		en = 1'b0;
		setFlags = 1'b0;
		wa = '0;
		res = '0;
		nf = '0;
		expNext = mPc + word_t'(1);
		// z,c,n,v sit at bits 3..0.
		fv = mFlags;
		if (ins[15:14] == GRP_JUMP) begin
			cond = !ins[13] || (fv[3 - ins[9:8]] ^ ins[12]);
			case (jpf_t'(ins[11:10]))
				JPF_ABS_R:  b = mRegs[ins[2:0]];
				JPF_REL_S8: b = word_t'($signed(ins[7:0]));
				default:    b = {ins[7:0], mRegs[`RB_INDEX][7:0]};
			endcase
			// relative types add the pc.
			target = ins[11] ? mPc + b : b;
			if (cond) begin
				expNext = target;
				if (!ins[11]) begin
					en = 1'b1;
					wa = regAddr_t'(`RL_INDEX);
					res = mPc + word_t'(1);
				end
			end
			// direction of a conditional jump shows the selected flag.
			if (ins[13] && (target != mPc + word_t'(1))) begin
				fv[3 - ins[9:8]] = (retire.nextPc == target) ^ ins[12];
				checkFlags("flags", flags_t'(fv), mFlags);
			end
		end else if (ins[15:14] == GRP_ALU) begin
			a = mRegs[ins[6:4]];
			b = (ins[9:8] == ARGF_IMM4) ? word_t'(ins[3:0]) : mRegs[ins[2:0]];
			sa = $signed(a);
			sb = $signed(b);
			case (ins[13:10])
				ALU_ADD: begin
					res = a + b;
					nf.c = (int'(a) + int'(b)) > 65535;
					nf.v = (sa + sb > 32767) || (sa + sb < -32768);
				end
				ALU_SUB, ALU_CMP: begin
					res = a - b;
					// borrow.
					nf.c = a < b;
					nf.v = (sa - sb > 32767) || (sa - sb < -32768);
				end
				ALU_AND: res = a & b;
				ALU_OR:  res = a | b;
				ALU_XOR: res = a ^ b;
				default: res = b;
			endcase
			nf.z = (res == '0);
			nf.n = res[15];
			en = (ins[13:10] <= ALU_MOV);
			setFlags = (ins[13:10] <= ALU_CMP) && (ins[13:10] != ALU_MOV);
			wa = regAddr_t'(ins[6:4]);
		end
		checkWord("instrAddr", instrAddr, mPc);
		checkWord("retire.pc", retire.pc, mPc);
		checkWord("retire.nextPc", retire.nextPc, expNext);
		checkWrite(en, wa, res);
		if (en) mRegs[wa] = res;
		if (setFlags) mFlags = nf;
		mPc = expNext;
	endtask

	initial begin
		int gap;
		void'($urandom(71731));
		CLK = 1'b0;
		reset = 1'b1;
		instr = '0;
		valueErrors = 0;
		otherErrors = 0;
		cycles = 0;
		mPc = '0;
		mFlags = '0;
		mRegs = '{default: '0};
		foreach (rom[i]) rom[i] = randomInstr();
		// borrow then carry, each seen by a conditional jump.
		rom[0] = aluInstr(ALU_MOV, ARGF_IMM4, 4'd1, 4'd15);
		rom[1] = aluInstr(ALU_SUB, ARGF_IMM4, 4'd2, 4'd1);
		rom[2] = jumpInstr(2'b10, JPF_REL_S8, CC_C, 8'd2);
		rom[3] = aluInstr(ALU_XOR, ARGF_REG, 4'd3, 4'd3);
		rom[4] = aluInstr(ALU_ADD, ARGF_IMM4, 4'd2, 4'd1);
		rom[5] = jumpInstr(2'b11, JPF_REL_S8, CC_Z, 8'd2);
		repeat (resetCycles) @(posedge CLK);
		@(negedge CLK);
		reset = 1'b0;
		checkWord("instrAddr", instrAddr, '0);
		if (retire.valid !== 1'b0) begin
			otherErrors++;
			$display("retire is active in the first cycle after reset");
		end
		for (int n = 0; n < retireCount; n++) begin
			gap = 0;
			do begin
				@(negedge CLK);
				gap++;
			end while (retire.valid !== 1'b1);
			// first pulse in the fourth cycle after reset.
			if (gap != ((n == 0) ? 3 : 4)) begin
				otherErrors++;
				$display("retire %0d came %0d cycles after the previous one", n, gap);
			end
			retireAndCheck();
		end
		$display("errors: %0d value mismatches, %0d other failures", valueErrors, otherErrors);
		if ((valueErrors == 0) && (otherErrors == 0)) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- testbench/cpuCore_assert.sv
`default_nettype none

module cpuCore_assert (
	input logic              CLK,
	input logic              reset,
	input corePkg::retire_t  retire,
	input corePkg::regCtrl_t regCtrl,
	input corePkg::word_t    pc
);
	timeunit 1ns;
	timeprecision 1ps;

	// one retirement every fourth cycle.
	retireSpacing: assert property (@(posedge CLK) disable iff (reset)
		retire.valid |=> !retire.valid ##1 !retire.valid ##1 !retire.valid ##1 retire.valid)
		else $error("retire pulses are not four cycles apart");

	// pc moves only at the end of commit.
	pcAfterRetire: assert property (@(posedge CLK) disable iff (reset)
		!$stable(pc) |-> $past(retire.valid))
		else $error("pc changed without a retire in the previous cycle");

	// register file writes only while retiring.
	writeInRetire: assert property (@(posedge CLK) disable iff (reset)
		regCtrl.writeEn |-> retire.valid)
		else $error("register write outside the retire cycle");

endmodule

bind cpuCore cpuCore_assert assertChecks (
	.CLK(CLK), .reset(reset), .retire(retire), .regCtrl(regCtrl), .pc(pc)
);

`default_nettype wire

//--- hw/cpuCore.sv
`default_nettype none

module cpuCore (
	input  logic             CLK,
	input  logic             reset,
	input  isaPkg::instr_t   instr,
	output corePkg::word_t   instrAddr,
	output corePkg::retire_t retire
);
	import isaPkg::*;
	import corePkg::*;

	instr_t    instrReg;
	jumpCtrl_t jumpCtrl;
	aluCtrl_t  aluCtrl;
	execCtrl_t execCtrl;
	regCtrl_t  regCtrl;
	logic      retireValid;
	logic      taken;
	logic      linkWrite;
	word_t     readA;
	word_t     readB;
	word_t     opB;
	word_t     result;
	word_t     writeData;
	word_t     pc;
	word_t     nextPc;
	flags_t    flags;

	phaseSequencer sequencer (
		.CLK(CLK), .reset(reset), .instr(instr), .jumpCtrl(jumpCtrl),
		.aluCtrl(aluCtrl), .instrReg(instrReg), .execCtrl(execCtrl),
		.retireValid(retireValid)
	);

	jumpGroupDecoder jumpDecoder (.instrReg(instrReg), .jumpCtrl(jumpCtrl));
	aluGroupDecoder aluDecoder (.instrReg(instrReg), .aluCtrl(aluCtrl));

	// link written only when the jump is taken.
	assign linkWrite = execCtrl.jump.regCtrl.writeEn && taken;

	always_comb begin
		regCtrl = execCtrl.jump.valid ? execCtrl.jump.regCtrl : execCtrl.alu.regCtrl;
		regCtrl.writeEn = linkWrite || execCtrl.alu.regCtrl.writeEn;
	end

	// return address or ALU result.
	assign writeData = linkWrite ? pc + word_t'(1) : result;

	registerFile regFile (
		.CLK(CLK), .reset(reset), .regCtrl(regCtrl), .writeData(writeData),
		.readA(readA), .readB(readB)
	);

	alu aluUnit (
		.CLK(CLK), .reset(reset), .execCtrl(execCtrl), .instrReg(instrReg),
		.readA(readA), .readB(readB), .opB(opB), .result(result), .flags(flags)
	);

	programCounter pcUnit (
		.CLK(CLK), .reset(reset), .execCtrl(execCtrl), .flags(flags), .opB(opB),
		.pc(pc), .nextPc(nextPc), .taken(taken)
	);

	assign instrAddr = pc;

	// report of the instruction retiring this cycle.
	assign retire = '{
		valid:     retireValid,
		pc:        pc,
		nextPc:    nextPc,
		writeEn:   regCtrl.writeEn,
		writeAddr: regCtrl.writeAddr,
		writeData: writeData
	};

endmodule

`default_nettype wire

//--- hw/programCounter.sv
`default_nettype none

module programCounter (
	input  logic               CLK,
	input  logic               reset,
	input  corePkg::execCtrl_t execCtrl,
	input  corePkg::flags_t    flags,
	input  corePkg::word_t     opB,
	output corePkg::word_t     pc,
	output corePkg::word_t     nextPc,
	output logic               taken
);
	import isaPkg::*;
	import corePkg::*;

	logic  flagBit;
	logic  condition;
	word_t target;
	word_t targetReg;

	// flags as committed by earlier instructions.
	always_comb begin
		case (execCtrl.jump.ccSel)
			CC_Z:    flagBit = flags.z;
			CC_C:    flagBit = flags.c;
			CC_N:    flagBit = flags.n;
			default: flagBit = flags.v;
		endcase
		// unconditional unless apply is set.
		condition = !execCtrl.jump.apply || (flagBit ^ execCtrl.jump.invert);
	end

	assign target = execCtrl.jump.relative ? pc + opB : opB;

	// no-op controls keep jump low, so taken only for group 2.
	always_ff @(posedge CLK) begin
		if (reset) begin
			pc <= '0;
			taken <= 1'b0;
		end else begin
			if (execCtrl.phase == EXECUTE) begin
				taken <= execCtrl.jump.jump && condition;
			end
			if (execCtrl.phase == COMMIT) begin
				pc <= nextPc;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (execCtrl.phase == EXECUTE) begin
			targetReg <= target;
		end
	end

	assign nextPc = taken ? targetReg : pc + word_t'(1);

endmodule

`default_nettype wire

//--- hw/alu.sv
`include "cpu_config.svh"

`default_nettype none

module alu (
	input  logic               CLK,
	input  logic               reset,
	input  corePkg::execCtrl_t execCtrl,
	input  isaPkg::instr_t     instrReg,
	input  corePkg::word_t     readA,
	input  corePkg::word_t     readB,
	output corePkg::word_t     opB,
	output corePkg::word_t     result,
	output corePkg::flags_t    flags
);
	import isaPkg::*;
	import corePkg::*;

	localparam int signBit = `WORD_WIDTH - 1;
	localparam int immPad = `WORD_WIDTH - 8;

	opBSrc_t opBSrc;
	word_t   nextResult;
	flags_t  nextFlags;
	flags_t  pendingFlags;
	logic    carry;

	// owner group picks the source.
	assign opBSrc = execCtrl.jump.valid ? execCtrl.jump.opBSrc : execCtrl.alu.opBSrc;

	always_comb begin
		case (opBSrc)
			OPB_U8H:  opB = {instrReg[7:0], readB[7:0]};
			OPB_S8:   opB = {{immPad{instrReg[7]}}, instrReg[7:0]};
			OPB_IMM4: opB = word_t'(instrReg[3:0]);
			default:  opB = readB;
		endcase
	end

	always_comb begin
		carry = 1'b0;
		nextFlags = '0;
		case (execCtrl.alu.op)
			ALU_ADD: begin
				{carry, nextResult} = {1'b0, readA} + {1'b0, opB};
				// same signs in, other sign out.
				nextFlags.v = (readA[signBit] == opB[signBit]) &&
					(nextResult[signBit] != readA[signBit]);
			end
			ALU_SUB, ALU_CMP: begin
				// carry holds the borrow.
				{carry, nextResult} = {1'b0, readA} - {1'b0, opB};
				nextFlags.v = (readA[signBit] != opB[signBit]) &&
					(nextResult[signBit] != readA[signBit]);
			end
			ALU_AND: nextResult = readA & opB;
			ALU_OR:  nextResult = readA | opB;
			ALU_XOR: nextResult = readA ^ opB;
			ALU_MOV: nextResult = opB;
			default: nextResult = readA;
		endcase
		nextFlags.c = carry;
		nextFlags.z = (nextResult == '0);
		nextFlags.n = nextResult[signBit];
	end

	// result and pending flags held until commit.
	always_ff @(posedge CLK) begin
		if (execCtrl.phase == EXECUTE) begin
			result <= nextResult;
			pendingFlags <= nextFlags;
		end
	end

	// visible flags change only at retirement.
	always_ff @(posedge CLK) begin
		if (reset) begin
			flags <= '0;
		end else if ((execCtrl.phase == COMMIT) && execCtrl.alu.writeFlags) begin
			flags <= pendingFlags;
		end
	end

endmodule

`default_nettype wire

//--- hw/registerFile.sv
`include "cpu_config.svh"

`default_nettype none

module registerFile (
	input  logic              CLK,
	input  logic              reset,
	input  corePkg::regCtrl_t regCtrl,
	input  corePkg::word_t    writeData,
	output corePkg::word_t    readA,
	output corePkg::word_t    readB
);
	import corePkg::*;

	word_t regs [`REG_COUNT];

	// single write port, clocked.
	always_ff @(posedge CLK) begin
		if (reset) begin
			regs <= '{default: '0};
		end else if (regCtrl.writeEn) begin
			regs[regCtrl.writeAddr] <= writeData;
		end
	end

	// async read ports.
	assign readA = regs[regCtrl.addrA];
	assign readB = regs[regCtrl.addrB];

endmodule

`default_nettype wire

//--- decoder/aluGroupDecoder.sv
`default_nettype none

module aluGroupDecoder (
	input  isaPkg::instr_t    instrReg,
	output corePkg::aluCtrl_t aluCtrl
);
	import isaPkg::*;
	import corePkg::*;

	aluInstr_t fields;
	aluOp_t    op;
	logic      knownOp;

	assign fields = aluInstr_t'(instrReg);

	// codes past CMP are undefined.
	assign op = aluOp_t'(fields.aluf);
	assign knownOp = (fields.aluf <= aluf_t'(ALU_CMP));

	always_comb begin
		aluCtrl = '0;
		aluCtrl.valid = (fields.group == GRP_ALU);
		aluCtrl.op = op;
		// unused ARGF codes read a register.
		aluCtrl.opBSrc = (fields.argf == ARGF_IMM4) ? OPB_IMM4 : OPB_REG_B;
		// mov leaves flags alone.
		aluCtrl.writeFlags = knownOp && (op != ALU_MOV);
		// result lands in ARGA.
		aluCtrl.regCtrl.addrA = regAddr_t'(fields.argA);
		aluCtrl.regCtrl.addrB = regAddr_t'(fields.argB);
		aluCtrl.regCtrl.writeAddr = regAddr_t'(fields.argA);
		// cmp only sets flags.
		aluCtrl.regCtrl.writeEn = knownOp && (op != ALU_CMP);
	end

endmodule

`default_nettype wire

//--- decoder/jumpGroupDecoder.sv
`include "cpu_config.svh"

`default_nettype none

module jumpGroupDecoder (
	input  isaPkg::instr_t     instrReg,
	output corePkg::jumpCtrl_t jumpCtrl
);
	import isaPkg::*;
	import corePkg::*;

	jumpInstr_t fields;

	assign fields = jumpInstr_t'(instrReg);

	always_comb begin
		jumpCtrl = '0;
		// only group 2 claims the slot.
		jumpCtrl.valid = (fields.group == GRP_JUMP);
		jumpCtrl.jump = 1'b1;
		// condition fields pass straight through.
		jumpCtrl.apply = fields.apply;
		jumpCtrl.invert = fields.invert;
		jumpCtrl.ccSel = fields.ccSel;
		// port A and the write port sit on the link register.
		jumpCtrl.regCtrl.addrA = regAddr_t'(`RL_INDEX);
		jumpCtrl.regCtrl.writeAddr = regAddr_t'(`RL_INDEX);

		case (fields.jpf)
			JPF_ABS_R: begin
				// target is register ARGB.
				jumpCtrl.relative = 1'b0;
				jumpCtrl.opBSrc = OPB_REG_B;
				jumpCtrl.regCtrl.addrB = regAddr_t'(fields.argB);
				jumpCtrl.regCtrl.writeEn = 1'b1;
			end

			JPF_ABS_U8H: begin
				// target is imm byte over RB low byte.
				jumpCtrl.relative = 1'b0;
				jumpCtrl.opBSrc = OPB_U8H;
				jumpCtrl.regCtrl.addrB = regAddr_t'(`RB_INDEX);
				jumpCtrl.regCtrl.writeEn = 1'b1;
			end

			JPF_REL_S8: begin
				// signed byte offset from pc.
				jumpCtrl.relative = 1'b1;
				jumpCtrl.opBSrc = OPB_S8;
				jumpCtrl.regCtrl.addrB = regAddr_t'(fields.argB);
				jumpCtrl.regCtrl.writeEn = 1'b0;
			end

			default: begin
				// U8H.RBL composite added to pc.
				jumpCtrl.relative = 1'b1;
				jumpCtrl.opBSrc = OPB_U8H;
				jumpCtrl.regCtrl.addrB = regAddr_t'(`RB_INDEX);
				jumpCtrl.regCtrl.writeEn = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- hw/phaseSequencer.sv
`default_nettype none

module phaseSequencer (
	input  logic               CLK,
	input  logic               reset,
	input  isaPkg::instr_t     instr,
	input  corePkg::jumpCtrl_t jumpCtrl,
	input  corePkg::aluCtrl_t  aluCtrl,
	output isaPkg::instr_t     instrReg,
	output corePkg::execCtrl_t execCtrl,
	output logic               retireValid
);
	import corePkg::*;

	phase_t phase;

	// fixed four step cycle, no stalls.
	always_ff @(posedge CLK) begin
		if (reset) begin
			phase <= FETCH;
			instrReg <= '0;
		end else begin
			case (phase)
				FETCH:   phase <= DECODE;
				DECODE:  phase <= EXECUTE;
				EXECUTE: phase <= COMMIT;
				default: phase <= FETCH;
			endcase
			// rom answers in the fetch cycle.
			if (phase == FETCH) begin
				instrReg <= instr;
			end
		end
	end

	// pick the decoder that owns the group, zero means no-op.
	always_comb begin
		execCtrl.jump = jumpCtrl.valid ? jumpCtrl : '0;
		execCtrl.alu = aluCtrl.valid ? aluCtrl : '0;
		execCtrl.phase = phase;
		// state changes only in commit.
		if (phase != COMMIT) begin
			execCtrl.jump.regCtrl.writeEn = 1'b0;
			execCtrl.alu.regCtrl.writeEn = 1'b0;
			execCtrl.alu.writeFlags = 1'b0;
		end
	end

	assign retireValid = (phase == COMMIT);

endmodule

`default_nettype wire

//--- common/corePkg.sv
`include "cpu_config.svh"

`default_nettype none

package corePkg;

	typedef logic [`WORD_WIDTH-1:0] word_t;
	typedef logic [$clog2(`REG_COUNT)-1:0] regAddr_t;

	// condition flags.
	typedef struct packed {
		logic z;
		logic c;
		logic n;
		logic v;
	} flags_t;

	// one phase per cycle, four per instruction.
	typedef enum logic [1:0] {
		FETCH   = 2'd0,
		DECODE  = 2'd1,
		EXECUTE = 2'd2,
		COMMIT  = 2'd3
	} phase_t;

	// operand B source.
	typedef enum logic [1:0] {
		OPB_REG_B = 2'd0,
		OPB_U8H   = 2'd1,
		OPB_S8    = 2'd2,
		OPB_IMM4  = 2'd3
	} opBSrc_t;

	// register file addressing and write strobe.
	typedef struct packed {
		regAddr_t addrA;
		regAddr_t addrB;
		regAddr_t writeAddr;
		logic     writeEn;
	} regCtrl_t;

	// jump group controls.
	typedef struct packed {
		logic           valid;
		logic           jump;
		logic           relative;
		logic           apply;
		logic           invert;
		isaPkg::ccSel_t ccSel;
		opBSrc_t        opBSrc;
		regCtrl_t       regCtrl;
	} jumpCtrl_t;

	// ALU group controls.
	typedef struct packed {
		logic           valid;
		isaPkg::aluOp_t op;
		opBSrc_t        opBSrc;
		logic           writeFlags;
		regCtrl_t       regCtrl;
	} aluCtrl_t;

	// merged controls, at most one group valid.
	typedef struct packed {
		jumpCtrl_t jump;
		aluCtrl_t  alu;
		phase_t    phase;
	} execCtrl_t;

	// retirement report, valid in COMMIT.
	typedef struct packed {
		logic     valid;
		word_t    pc;
		word_t    nextPc;
		logic     writeEn;
		regAddr_t writeAddr;
		word_t    writeData;
	} retire_t;

endpackage

`default_nettype wire

//--- common/isaPkg.sv
`default_nettype none

package isaPkg;

	// raw instruction word.
	typedef logic [15:0] instr_t;

	// register or immediate argument field.
	typedef logic [3:0] arg_t;

	// ALU operation field, wider than the known codes.
	typedef logic [3:0] aluf_t;

	// group in bits 15:14.
	typedef enum logic [1:0] {
		GRP_SYSTEM    = 2'd0,
		GRP_LOADSTORE = 2'd1,
		GRP_JUMP      = 2'd2,
		GRP_ALU       = 2'd3
	} group_t;

	// jump type, absolute kinds also link.
	typedef enum logic [1:0] {
		JPF_ABS_R   = 2'd0,
		JPF_ABS_U8H = 2'd1,
		JPF_REL_S8  = 2'd2,
		JPF_REL_U8H = 2'd3
	} jpf_t;

	// condition flag select.
	typedef enum logic [1:0] {
		CC_Z = 2'd0,
		CC_C = 2'd1,
		CC_N = 2'd2,
		CC_V = 2'd3
	} ccSel_t;

	// codes above CMP are undefined and retire without effect.
	typedef enum logic [3:0] {
		ALU_ADD = 4'd0,
		ALU_SUB = 4'd1,
		ALU_AND = 4'd2,
		ALU_OR  = 4'd3,
		ALU_XOR = 4'd4,
		ALU_MOV = 4'd5,
		ALU_CMP = 4'd6
	} aluOp_t;

	// second operand kind, unused codes behave as register.
	typedef enum logic [1:0] {
		ARGF_REG  = 2'd0,
		ARGF_IMM4 = 2'd1
	} argf_t;

	// group 2 field layout.
	typedef struct packed {
		group_t group;
		logic   apply;
		logic   invert;
		jpf_t   jpf;
		ccSel_t ccSel;
		arg_t   argA;
		arg_t   argB;
	} jumpInstr_t;

	// group 3 field layout.
	typedef struct packed {
		group_t group;
		aluf_t  aluf;
		argf_t  argf;
		arg_t   argA;
		arg_t   argB;
	} aluInstr_t;

endpackage

`default_nettype wire

//--- common/cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

`default_nettype none

// data and address width.
`define WORD_WIDTH 16

// size of the register file.
`define REG_COUNT 8

// link register, target of the return address.
`define RL_INDEX 7

// base register, low byte feeds the U8H.RBL target.
`define RB_INDEX 6

`default_nettype wire

`endif
